// ==== hw/uart_pkg.sv ====
package uart_pkg;

  // Serial bit timing
  localparam int CLOCK_FREQ_HZ  = 10_000_000;
  localparam int BAUD_RATE      = 1_000_000;
  localparam int CLOCKS_PER_BIT = CLOCK_FREQ_HZ / BAUD_RATE;

  // Start edge to the middle of the start bit
  localparam int HALF_BIT       = CLOCKS_PER_BIT / 2;

  // Frame layout is 8N1
  localparam int DATA_BITS      = 8;
  localparam int FRAME_BITS     = DATA_BITS + 2;

  // Counter widths shared by the transmitter and the receiver
  localparam int CYCLE_CNT_W    = $clog2(CLOCKS_PER_BIT);
  localparam int BIT_CNT_W      = $clog2(FRAME_BITS);

  // Entries in each of the two FIFOs
  localparam int FIFO_DEPTH     = 8;
  localparam int FIFO_PTR_W     = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W     = $clog2(FIFO_DEPTH + 1);

  // One data character on the line
  typedef logic [DATA_BITS-1:0] uart_byte_t;

  // Received character with its framing status
  typedef struct packed {
    uart_byte_t data;
    // Stop bit was sampled low
    logic       frame_err;
  } rx_char_t;

endpackage

// ==== hw/stream_fifo.sv ====
`timescale 1ns/100ps

module stream_fifo
  import uart_pkg::*;
#(
  parameter type PAYLOAD_T = uart_byte_t
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  PAYLOAD_T in_data,
  output logic     in_ready,
  output logic     out_valid,
  output PAYLOAD_T out_data,
  input  logic     out_ready
);

  PAYLOAD_T              mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  push;
  logic                  pop;

  // Circular pointer advance, also correct for depths that are not a power of two
  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign in_ready  = (count != FIFO_CNT_W'(FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       byte_valid,
  input  uart_byte_t byte_data,
  output logic       byte_ready,
  output logic       tx_pin
);

  logic                   busy;
  logic [FRAME_BITS-1:0]  frame;
  logic [CYCLE_CNT_W-1:0] cycle_cnt;
  logic [BIT_CNT_W-1:0]   bit_cnt;
  logic                   accept;
  logic                   bit_done;
  logic                   frame_done;

  assign byte_ready = !busy;
  assign accept     = byte_valid && byte_ready;

  // Last cycle of the current bit
  assign bit_done = (cycle_cnt == CYCLE_CNT_W'(CLOCKS_PER_BIT - 1));

  // Release one cycle before the stop bit ends so that a
  // queued byte starts right where the stop bit finishes
  assign frame_done = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) &&
                      (cycle_cnt == CYCLE_CNT_W'(CLOCKS_PER_BIT - 2));

  // Bit 0 of the frame register is the line, so the pin comes straight from a flop
  assign tx_pin = frame[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      frame     <= '1;
      cycle_cnt <= '0;
      bit_cnt   <= '0;
    end else if (accept) begin
      busy      <= 1'b1;
      // Stop bit, data LSB first, start bit
      frame     <= {1'b1, byte_data, 1'b0};
      cycle_cnt <= '0;
      bit_cnt   <= '0;
    end else if (busy) begin
      if (frame_done) begin
        busy <= 1'b0;
      end
      if (bit_done) begin
        cycle_cnt <= '0;
        bit_cnt   <= bit_cnt + 1'b1;
        // Idle level shifts in behind the frame
        frame     <= {1'b1, frame[FRAME_BITS-1:1]};
      end else begin
        cycle_cnt <= cycle_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx
  import uart_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rx_pin,
  output logic     char_strobe,
  output rx_char_t char_data
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t              state;
  logic                   rx_meta;
  logic                   rx_sync;
  logic                   rx_prev;
  logic [CYCLE_CNT_W-1:0] cycle_cnt;
  logic [BIT_CNT_W-1:0]   bit_cnt;
  uart_byte_t             shift_reg;
  logic                   start_edge;
  logic                   half_done;
  logic                   bit_done;

  // Two flop synchronizer plus one flop of history for edge detection
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_pin;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // Only a high to low transition starts a frame, so a line stuck low
  // after a framing error must go high again first
  assign start_edge = rx_prev && !rx_sync;

  assign half_done = (cycle_cnt == CYCLE_CNT_W'(HALF_BIT - 1));
  assign bit_done  = (cycle_cnt == CYCLE_CNT_W'(CLOCKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= RX_IDLE;
      cycle_cnt   <= '0;
      bit_cnt     <= '0;
      char_strobe <= 1'b0;
    end else begin
      char_strobe <= 1'b0;
      case (state)
        RX_IDLE: begin
          cycle_cnt <= '0;
          if (start_edge) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (half_done) begin
            cycle_cnt <= '0;
            bit_cnt   <= '0;
            // Line back high at mid start bit means a glitch
            state     <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_done) begin
            cycle_cnt <= '0;
            bit_cnt   <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1)) begin
              state <= RX_STOP;
            end
          end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_done) begin
            char_strobe <= 1'b1;
            state       <= RX_IDLE;
          end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data path, LSB arrives first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_done) begin
      shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
    end
    if (state == RX_STOP && bit_done) begin
      char_data.data      <= shift_reg;
      char_data.frame_err <= !rx_sync;
    end
  end

endmodule

// ==== hw/uart_subsys.sv ====
`timescale 1ns/100ps

module uart_subsys
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_valid,
  input  uart_byte_t tx_data,
  output logic       tx_ready,
  output logic       tx_pin,
  input  logic       rx_pin,
  output logic       rx_valid,
  output uart_byte_t rx_data,
  output logic       rx_frame_err,
  input  logic       rx_ready,
  output logic       rx_overrun
);

  logic       txq_valid;
  uart_byte_t txq_data;
  logic       txq_ready;
  logic       char_strobe;
  rx_char_t   char_data;
  logic       rxq_ready;
  rx_char_t   rxq_char;

  // Transmit path
  stream_fifo #(
    .PAYLOAD_T(uart_byte_t)
  ) i_tx_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (tx_valid),
    .in_data  (tx_data),
    .in_ready (tx_ready),
    .out_valid(txq_valid),
    .out_data (txq_data),
    .out_ready(txq_ready)
  );

  uart_tx i_uart_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .byte_valid(txq_valid),
    .byte_data (txq_data),
    .byte_ready(txq_ready),
    .tx_pin    (tx_pin)
  );

  // Receive path
  uart_rx i_uart_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_pin     (rx_pin),
    .char_strobe(char_strobe),
    .char_data  (char_data)
  );

  // The line cannot be stalled, so a character that meets a full FIFO is lost
  stream_fifo #(
    .PAYLOAD_T(rx_char_t)
  ) i_rx_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (char_strobe && rxq_ready),
    .in_data  (char_data),
    .in_ready (rxq_ready),
    .out_valid(rx_valid),
    .out_data (rxq_char),
    .out_ready(rx_ready)
  );

  assign rx_data      = rxq_char.data;
  assign rx_frame_err = rxq_char.frame_err;

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_overrun <= 1'b0;
    end else if (char_strobe && !rxq_ready) begin
      rx_overrun <= 1'b1;
    end
  end

endmodule

// ==== verif/uart_tb_util.svh ====
`ifndef UART_TB_UTIL_SVH
`define UART_TB_UTIL_SVH

// Xorshift32 step on a state that each caller keeps for itself
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// Compare one value with its expected value and stop at the first mismatch
task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
  if (actual !== expected) begin
    $display("FAILED at time %0t: %s (got 0x%0h, expected 0x%0h)",
             $time, what, actual, expected);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at the first mismatch");
  end
endtask

// Expected 8N1 line levels for one byte with bit 0 going out first
function automatic logic [FRAME_BITS-1:0] frame_bits(input uart_byte_t b);
  logic [FRAME_BITS-1:0] f;
  f[0] = 1'b0;
  for (int i = 0; i < DATA_BITS; i++) begin
    f[i+1] = b[i];
  end
  f[FRAME_BITS-1] = 1'b1;
  return f;
endfunction

// Drive one frame on the bit-bang pin followed by one idle bit time
// Call on a falling edge
task automatic send_frame(input uart_byte_t b, input logic stop_bit);
  logic [FRAME_BITS-1:0] bits;
  bits = frame_bits(b);
  bits[FRAME_BITS-1] = stop_bit;
  for (int i = 0; i < FRAME_BITS; i++) begin
    bb_pin = bits[i];
    repeat (CLOCKS_PER_BIT) @(negedge clk);
  end
  // Line must go high again before the next start edge counts
  bb_pin = 1'b1;
  repeat (CLOCKS_PER_BIT) @(negedge clk);
endtask

`endif

// ==== verif/uart_subsys_tb.sv ====
`timescale 1ns/100ps

module uart_subsys_tb
  import uart_pkg::*;
();

  localparam logic [31:0] SEED = 32'h256d;
  localparam int SHAPE_FRAMES  = 18;
  localparam int STREAM_BYTES  = 40;
  localparam int FERR_FRAMES   = 3;
  localparam int OVR_FRAMES    = FIFO_DEPTH + 2;
  localparam int FALSE_FRAMES  = 1;
  localparam int NUM_FRAMES    = SHAPE_FRAMES + STREAM_BYTES + FERR_FRAMES +
                                 OVR_FRAMES + FALSE_FRAMES;
  localparam int FRAME_CYCLES  = FRAME_BITS * CLOCKS_PER_BIT;
  localparam int TIMEOUT_LIMIT = NUM_FRAMES * FRAME_CYCLES * 2 + 1000;

  // 55, AA, 00, FF, the eight single-bit bytes and "Serial"
  localparam uart_byte_t SHAPE_PATTERNS [SHAPE_FRAMES] = '{
    8'h55, 8'hAA, 8'h00, 8'hFF,
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80,
    8'h53, 8'h65, 8'h72, 8'h69, 8'h61, 8'h6C
  };

  logic       clk;
  logic       rst_n;
  logic       tx_valid;
  uart_byte_t tx_data;
  logic       tx_ready;
  logic       tx_pin;
  logic       rx_pin;
  logic       rx_valid;
  uart_byte_t rx_data;
  logic       rx_frame_err;
  logic       rx_ready;
  logic       rx_overrun;

  // Bit-bang source that replaces the loopback on the receiver pin
  logic        bb_sel;
  logic        bb_pin;
  rx_char_t    exp_q[$];
  rx_char_t    sb_char;
  int          cycle_count;
  logic [31:0] tx_rng;
  logic [31:0] rdy_rng;
  logic        stream_done;
  uart_byte_t  stim_byte;

  `include "uart_tb_util.svh"

  uart_subsys i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx_valid    (tx_valid),
    .tx_data     (tx_data),
    .tx_ready    (tx_ready),
    .tx_pin      (tx_pin),
    .rx_pin      (rx_pin),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .rx_frame_err(rx_frame_err),
    .rx_ready    (rx_ready),
    .rx_overrun  (rx_overrun)
  );

  assign rx_pin = bb_sel ? bb_pin : tx_pin;

  always #2 clk = ~clk;

  task automatic expect_char(input uart_byte_t b, input logic err);
    rx_char_t c;
    c.data      = b;
    c.frame_err = err;
    exp_q.push_back(c);
  endtask

  // Offer one byte from a falling edge and return on the falling edge after the transfer
  task automatic push_byte(input uart_byte_t b);
    tx_valid = 1'b1;
    tx_data  = b;
    while (!tx_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    tx_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // Return once rx_pin has stayed high for n cycles in a row
  task automatic wait_line_idle(input int n);
    int run;
    run = 0;
    while (run < n) begin
      @(negedge clk);
      if (rx_pin) begin
        run++;
      end else begin
        run = 0;
      end
    end
  endtask

  // Send a byte and sample tx_pin in the middle of each of its bits
  task automatic check_frame_shape(input uart_byte_t b);
    logic [FRAME_BITS-1:0] seen;
    expect_char(b, 1'b0);
    push_byte(b);
    while (tx_pin) begin
      @(negedge clk);
    end
    for (int k = 0; k < FRAME_BITS; k++) begin
      repeat ((k == 0) ? HALF_BIT : CLOCKS_PER_BIT) @(negedge clk);
      seen[k] = tx_pin;
    end
    check_eq(seen, frame_bits(b), $sformatf("frame shape of byte 0x%02h", b));
  endtask

  // Scoreboard pops one entry per receive transfer
  always @(posedge clk) begin
    if (rst_n && rx_valid && rx_ready) begin
      if (exp_q.size() == 0) begin
        $display("Received character 0x%02h that was never sent", rx_data);
        $display("CHECKS FAILED");
        $fatal(1, "unexpected character on the receive side");
      end else begin
        sb_char = exp_q.pop_front();
        check_eq(rx_data, sb_char.data, "received data");
        check_eq(rx_frame_err, sb_char.frame_err, "received framing status");
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_LIMIT) begin
      $display("Simulation timed out after %0d cycles", cycle_count);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    tx_valid    = 1'b0;
    tx_data     = '0;
    rx_ready    = 1'b1;
    bb_sel      = 1'b1;
    bb_pin      = 1'b1;
    cycle_count = 0;
    tx_rng      = SEED;
    rdy_rng     = ~SEED;
    stream_done = 1'b0;

    repeat (10) @(negedge clk);
    rst_n  = 1'b1;
    bb_sel = 1'b0;
    @(negedge clk);

    // Idle state after reset
    check_eq(tx_ready, 1'b1, "tx_ready after reset");
    check_eq(tx_pin, 1'b1, "tx_pin after reset");
    check_eq(rx_valid, 1'b0, "rx_valid after reset");
    check_eq(rx_overrun, 1'b0, "rx_overrun after reset");

    for (int n = 0; n < SHAPE_FRAMES; n++) begin
      check_frame_shape(SHAPE_PATTERNS[n]);
    end
    wait_drained();

    // Random stream with gaps on both sides
    fork
      begin
        for (int n = 0; n < STREAM_BYTES; n++) begin
          tx_rng    = xorshift32(tx_rng);
          stim_byte = tx_rng[7:0];
          expect_char(stim_byte, 1'b0);
          push_byte(stim_byte);
          repeat (tx_rng[9:8]) @(negedge clk);
        end
        wait_drained();
        stream_done = 1'b1;
      end
      begin
        while (!stream_done) begin
          rdy_rng  = xorshift32(rdy_rng);
          rx_ready = (rdy_rng[1:0] != 2'b00);
          repeat (1 + rdy_rng[4:2]) @(negedge clk);
        end
        rx_ready = 1'b1;
      end
    join

    // Frames with a low stop bit followed by a clean one
    bb_sel = 1'b1;
    expect_char(8'hA5, 1'b1);
    send_frame(8'hA5, 1'b0);
    expect_char(8'h3C, 1'b1);
    send_frame(8'h3C, 1'b0);
    expect_char(8'h96, 1'b0);
    send_frame(8'h96, 1'b1);
    wait_drained();
    bb_sel = 1'b0;

    // Receive FIFO held full
    check_eq(rx_overrun, 1'b0, "rx_overrun before the overrun test");
    rx_ready = 1'b0;
    for (int n = 0; n < OVR_FRAMES; n++) begin
      tx_rng    = xorshift32(tx_rng);
      stim_byte = tx_rng[7:0];
      if (n < FIFO_DEPTH) begin
        expect_char(stim_byte, 1'b0);
      end
      push_byte(stim_byte);
    end
    while (!rx_overrun) begin
      @(negedge clk);
    end
    wait_line_idle(2 * FRAME_CYCLES);
    check_eq(rx_overrun, 1'b1, "rx_overrun stays set");
    rx_ready = 1'b1;
    wait_drained();
    // Receive side held so that a stray character stays at the FIFO output
    rx_ready = 1'b0;
    repeat (2) @(negedge clk);
    check_eq(rx_valid, 1'b0, "rx_valid after the kept characters");

    // Glitch shorter than half a bit
    bb_sel = 1'b1;
    bb_pin = 1'b0;
    repeat (HALF_BIT - 2) @(negedge clk);
    bb_pin = 1'b1;
    wait_line_idle(2 * FRAME_CYCLES);
    check_eq(rx_valid, 1'b0, "rx_valid after a false start");
    rx_ready = 1'b1;
    expect_char(8'h5E, 1'b0);
    send_frame(8'h5E, 1'b1);
    wait_drained();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+verif
hw/uart_pkg.sv
hw/stream_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_subsys.sv
verif/uart_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=uart_subsys_sim
LOG=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module uart_subsys_tb \
  -f compile.f \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi
